//--- riscvIsaPkg.sv
package riscvIsaPkg;

	localparam int XLEN = 32;

	// Major opcodes
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_SB  = 3'b000;
	localparam logic [2:0] F3_SH  = 3'b001;
	localparam logic [2:0] F3_SW  = 3'b010;

	// Register and immediate arithmetic
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SR      = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [6:0] F7_BASE    = 7'b0000000;
	localparam logic [6:0] F7_ALT     = 7'b0100000; // SUB and SRA

	localparam logic [XLEN-1:0] EBREAK_INSN = 32'h0010_0073;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
		ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
	} aluOpT;

	typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immKindT;

endpackage

//--- riscvCorePkg.sv
package riscvCorePkg;

	localparam int IMEM_AW = 12; // Byte address
	localparam int DMEM_AW = 12; // Word address
	localparam logic [IMEM_AW-1:0] RESET_PC = '0;

	typedef enum logic [1:0] {SRCA_RS1, SRCA_PC, SRCA_ZERO} srcASelT;
	typedef enum logic {SRCB_RS2, SRCB_IMM} srcBSelT;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wbSelT;

	// Encoding follows funct3[1:0] of loads and stores
	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} memSizeT;

	typedef struct packed {
		riscvIsaPkg::aluOpT aluOp;
		riscvIsaPkg::immKindT immKind;
		srcASelT srcA;
		srcBSelT srcB;
		logic regWrite;
		logic memRead;
		logic memWrite;
		memSizeT memSize;
		logic memUnsigned;
		wbSelT wbSel;
		logic branch;
		logic jal;
		logic jalr;
		logic halt; // EBREAK
	} ctrlT;

endpackage

//--- pcUnit.sv
`timescale 1ns/100ps

module pcUnit (
	input logic CLK,
	input logic RSTn,
	input riscvCorePkg::ctrlT ctrl,
	input logic aluLsb,
	input logic branchTaken,
	input logic [riscvIsaPkg::XLEN-1:0] imm,
	input logic [riscvIsaPkg::XLEN-1:0] jalrTarget,
	output logic [riscvCorePkg::IMEM_AW-1:0] pc,
	output logic [riscvCorePkg::IMEM_AW-1:0] pcPlus4,
	output logic running,
	output logic halt,
	output logic [31:0] numInst
);
	import riscvCorePkg::*;

	logic started; // Set one cycle after reset release
	logic [IMEM_AW-1:0] nextPc;
	logic [IMEM_AW-1:0] jalrPc;

	assign running = started & ~halt;
	assign pcPlus4 = pc + IMEM_AW'(4);
	assign jalrPc = {jalrTarget[IMEM_AW-1:1], jalrTarget[0] & ~aluLsb}; // Low bit off

	always_comb begin
		if (ctrl.halt)
			nextPc = pc;
		else if (ctrl.jalr)
			nextPc = jalrPc;
		else if (ctrl.jal || (ctrl.branch && branchTaken))
			nextPc = pc + imm[IMEM_AW-1:0];
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= RESET_PC;
			started <= 1'b0;
			halt <= 1'b0;
			numInst <= '0;
		end else begin
			started <= 1'b1;
			if (running) begin
				pc <= nextPc;
				numInst <= numInst + 32'd1; // EBREAK counts too
				if (ctrl.halt)
					halt <= 1'b1;
			end
		end
	end

endmodule

//--- controlDecoder.sv
`timescale 1ns/100ps

module controlDecoder (
	input logic [riscvIsaPkg::XLEN-1:0] insn,
	output riscvCorePkg::ctrlT ctrl
);
	import riscvIsaPkg::*;
	import riscvCorePkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [4:0] rd;
	logic legal;
	aluOpT arithOp;
	ctrlT dec;

	assign opcode = insn[6:0];
	assign rd = insn[11:7];
	assign funct3 = insn[14:12];
	assign funct7 = insn[31:25];

	// SUB only exists for register ops, SRAI uses funct7 too
	always_comb begin
		case (funct3)
			F3_ADD_SUB: arithOp = (opcode == OP_REG && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
			F3_SLL:     arithOp = ALU_SLL;
			F3_SLT:     arithOp = ALU_SLT;
			F3_SLTU:    arithOp = ALU_SLTU;
			F3_XOR:     arithOp = ALU_XOR;
			F3_SR:      arithOp = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
			F3_OR:      arithOp = ALU_OR;
			default:    arithOp = ALU_AND;
		endcase
	end

	always_comb begin
		dec = '0;
		legal = 1'b1;
		case (opcode)
			OP_LUI: begin
				dec.immKind = IMM_U;
				dec.srcA = SRCA_ZERO;
				dec.srcB = SRCB_IMM;
				dec.regWrite = 1'b1;
			end
			OP_AUIPC: begin
				dec.immKind = IMM_U;
				dec.srcA = SRCA_PC;
				dec.srcB = SRCB_IMM;
				dec.regWrite = 1'b1;
			end
			OP_JAL: begin
				dec.immKind = IMM_J;
				dec.jal = 1'b1;
				dec.regWrite = 1'b1;
				dec.wbSel = WB_PC4;
			end
			OP_JALR: begin
				dec.srcB = SRCB_IMM; // rs1 + imm in the ALU
				dec.jalr = 1'b1;
				dec.regWrite = 1'b1;
				dec.wbSel = WB_PC4;
				legal = (funct3 == 3'b000);
			end
			OP_BRANCH: begin
				dec.immKind = IMM_B;
				dec.branch = 1'b1;
				case (funct3)
					F3_BEQ:  dec.aluOp = ALU_EQ;
					F3_BNE:  dec.aluOp = ALU_NE;
					F3_BLT:  dec.aluOp = ALU_LT;
					F3_BGE:  dec.aluOp = ALU_GE;
					F3_BLTU: dec.aluOp = ALU_LTU;
					F3_BGEU: dec.aluOp = ALU_GEU;
					default: legal = 1'b0;
				endcase
			end
			OP_LOAD: begin
				dec.srcB = SRCB_IMM;
				dec.memRead = 1'b1;
				dec.regWrite = 1'b1;
				dec.wbSel = WB_MEM;
				dec.memSize = memSizeT'(funct3[1:0]);
				dec.memUnsigned = funct3[2];
				legal = funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
			end
			OP_STORE: begin
				dec.immKind = IMM_S;
				dec.srcB = SRCB_IMM;
				dec.memWrite = 1'b1;
				dec.memSize = memSizeT'(funct3[1:0]);
				legal = funct3 inside {F3_SB, F3_SH, F3_SW};
			end
			OP_IMM: begin
				dec.aluOp = arithOp;
				dec.srcB = SRCB_IMM;
				dec.regWrite = 1'b1;
				if (funct3 == F3_SLL)
					legal = (funct7 == F7_BASE);
				else if (funct3 == F3_SR)
					legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
			end
			OP_REG: begin
				dec.aluOp = arithOp;
				dec.regWrite = 1'b1;
				legal = (funct7 == F7_BASE) ||
					(funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SR));
			end
			OP_SYSTEM: begin
				dec.halt = 1'b1;
				legal = (insn == EBREAK_INSN); // ECALL and CSR fall out here
			end
			default: legal = 1'b0;
		endcase

		ctrl = legal ? dec : '0;
		ctrl.regWrite = legal & dec.regWrite & (rd != 5'd0); // x0 stays zero
	end

endmodule

//--- immGen.sv
`timescale 1ns/100ps

module immGen (
	input logic [riscvIsaPkg::XLEN-1:0] insn,
	input riscvIsaPkg::immKindT immKind,
	output logic [riscvIsaPkg::XLEN-1:0] imm
);
	import riscvIsaPkg::*;

	logic sign;

	assign sign = insn[31];

	always_comb begin
		case (immKind)
			IMM_I: imm = {{20{sign}}, insn[31:20]};
			IMM_S: imm = {{20{sign}}, insn[31:25], insn[11:7]};
			IMM_B: imm = {{19{sign}}, sign, insn[7], insn[30:25], insn[11:8], 1'b0};
			IMM_U: imm = {insn[31:12], 12'b0};
			IMM_J: imm = {{11{sign}}, sign, insn[19:12], insn[20], insn[30:21], 1'b0};
			default: imm = '0;
		endcase
	end

endmodule

//--- alu.sv
`timescale 1ns/100ps

module alu (
	input logic [riscvIsaPkg::XLEN-1:0] a,
	input logic [riscvIsaPkg::XLEN-1:0] b,
	input riscvIsaPkg::aluOpT op,
	output logic [riscvIsaPkg::XLEN-1:0] result,
	output logic cond
);
	import riscvIsaPkg::*;

	logic [4:0] shamt;
	logic ltS;
	logic ltU;

	assign shamt = b[4:0];
	assign ltS = $signed(a) < $signed(b);
	assign ltU = a < b;

	// Branch decision
	always_comb begin
		case (op)
			ALU_EQ:  cond = (a == b);
			ALU_NE:  cond = (a != b);
			ALU_LT:  cond = ltS;
			ALU_GE:  cond = ~ltS;
			ALU_LTU: cond = ltU;
			ALU_GEU: cond = ~ltU;
			default: cond = 1'b0;
		endcase
	end

	always_comb begin
		case (op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_SLL:  result = a << shamt;
			ALU_SLT:  result = XLEN'(ltS);
			ALU_SLTU: result = XLEN'(ltU);
			ALU_XOR:  result = a ^ b;
			ALU_SRL:  result = a >> shamt;
			ALU_SRA:  result = $signed(a) >>> shamt;
			ALU_OR:   result = a | b;
			ALU_AND:  result = a & b;
			default:  result = XLEN'(cond); // Compares
		endcase
	end

endmodule

//--- memAccess.sv
`timescale 1ns/100ps

module memAccess (
	input riscvCorePkg::ctrlT ctrl,
	input logic [riscvIsaPkg::XLEN-1:0] addr,
	input logic [riscvIsaPkg::XLEN-1:0] storeData,
	input logic [riscvIsaPkg::XLEN-1:0] aluResult,
	input logic [riscvCorePkg::IMEM_AW-1:0] pcPlus4,
	input logic [riscvIsaPkg::XLEN-1:0] dMemDi,
	output logic dMemCsn,
	output logic dMemWen,
	output logic [3:0] dMemBe,
	output logic [riscvCorePkg::DMEM_AW-1:0] dMemAddr,
	output logic [riscvIsaPkg::XLEN-1:0] dMemDout,
	output logic [riscvIsaPkg::XLEN-1:0] rfWd
);
	import riscvIsaPkg::*;
	import riscvCorePkg::*;

	logic [1:0] offset;
	logic [XLEN-1:0] shifted;
	logic [XLEN-1:0] loadValue;
	logic [3:0] lanes;

	assign offset = addr[1:0];
	assign dMemCsn = ~(ctrl.memRead | ctrl.memWrite);
	assign dMemWen = ~ctrl.memWrite;
	assign dMemAddr = addr[DMEM_AW+1:2];
	assign dMemBe = ctrl.memWrite ? lanes : 4'b0000;
	assign shifted = dMemDi >> {offset, 3'b000};

	// Lanes and replicated store data
	always_comb begin
		case (ctrl.memSize)
			MEM_BYTE: begin
				lanes = 4'b0001 << offset;
				dMemDout = {4{storeData[7:0]}};
			end
			MEM_HALF: begin
				lanes = offset[1] ? 4'b1100 : 4'b0011;
				dMemDout = {2{storeData[15:0]}};
			end
			default: begin
				lanes = 4'b1111;
				dMemDout = storeData;
			end
		endcase
	end

	always_comb begin
		case (ctrl.memSize)
			MEM_BYTE: loadValue = {{24{shifted[7] & ~ctrl.memUnsigned}}, shifted[7:0]};
			MEM_HALF: loadValue = {{16{shifted[15] & ~ctrl.memUnsigned}}, shifted[15:0]};
			default:  loadValue = dMemDi;
		endcase
	end

	always_comb begin
		case (ctrl.wbSel)
			WB_MEM:  rfWd = loadValue;
			WB_PC4:  rfWd = XLEN'(pcPlus4); // Link address
			default: rfWd = aluResult;
		endcase
	end

endmodule

//--- riscvTop.sv
`timescale 1ns/100ps

module riscvTop (
	input logic CLK,
	input logic RSTn,

	output logic iMemCsn,
	input logic [riscvIsaPkg::XLEN-1:0] iMemDi,
	output logic [riscvCorePkg::IMEM_AW-1:0] iMemAddr, // Byte address

	output logic dMemCsn,
	input logic [riscvIsaPkg::XLEN-1:0] dMemDi,
	output logic [riscvIsaPkg::XLEN-1:0] dMemDout,
	output logic [riscvCorePkg::DMEM_AW-1:0] dMemAddr, // Word address
	output logic dMemWen,
	output logic [3:0] dMemBe,

	output logic rfWe,
	output logic [4:0] rfRa1,
	output logic [4:0] rfRa2,
	output logic [4:0] rfWa1,
	input logic [riscvIsaPkg::XLEN-1:0] rfRd1,
	input logic [riscvIsaPkg::XLEN-1:0] rfRd2,
	output logic [riscvIsaPkg::XLEN-1:0] rfWd,

	output logic halt,
	output logic [31:0] numInst
);
	import riscvIsaPkg::*;
	import riscvCorePkg::*;

	ctrlT ctrl;
	ctrlT ctrlRun; // Idle while in reset or halted
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] srcA;
	logic [XLEN-1:0] srcB;
	logic [XLEN-1:0] aluResult;
	logic [IMEM_AW-1:0] pc;
	logic [IMEM_AW-1:0] pcPlus4;
	logic branchTaken;
	logic running;

	assign iMemAddr = pc;
	assign iMemCsn = ~running;
	assign rfRa1 = iMemDi[19:15];
	assign rfRa2 = iMemDi[24:20];
	assign rfWa1 = iMemDi[11:7];
	assign rfWe = ctrl.regWrite & running;
	assign ctrlRun = running ? ctrl : '0;

	always_comb begin
		case (ctrl.srcA)
			SRCA_PC:   srcA = XLEN'(pc);
			SRCA_ZERO: srcA = '0; // LUI
			default:   srcA = rfRd1;
		endcase
	end

	assign srcB = (ctrl.srcB == SRCB_IMM) ? imm : rfRd2;

	pcUnit pcUnit0 (
		.CLK(CLK),
		.RSTn(RSTn),
		.ctrl(ctrl),
		.aluLsb(aluResult[0]),
		.branchTaken(branchTaken),
		.imm(imm),
		.jalrTarget(aluResult),
		.pc(pc),
		.pcPlus4(pcPlus4),
		.running(running),
		.halt(halt),
		.numInst(numInst)
	);

	controlDecoder controlDecoder0 (
		.insn(iMemDi),
		.ctrl(ctrl)
	);

	immGen immGen0 (
		.insn(iMemDi),
		.immKind(ctrl.immKind),
		.imm(imm)
	);

	alu alu0 (
		.a(srcA),
		.b(srcB),
		.op(ctrl.aluOp),
		.result(aluResult),
		.cond(branchTaken)
	);

	memAccess memAccess0 (
		.ctrl(ctrlRun),
		.addr(aluResult),
		.storeData(rfRd2),
		.aluResult(aluResult),
		.pcPlus4(pcPlus4),
		.dMemDi(dMemDi),
		.dMemCsn(dMemCsn),
		.dMemWen(dMemWen),
		.dMemBe(dMemBe),
		.dMemAddr(dMemAddr),
		.dMemDout(dMemDout),
		.rfWd(rfWd)
	);

endmodule

//--- tbModels.sv
`timescale 1ns/100ps

module tbModels (
	input logic CLK,
	input logic [11:0] iMemAddr,
	output logic [31:0] iMemDi,
	input logic dMemCsn,
	input logic dMemWen,
	input logic [3:0] dMemBe,
	input logic [11:0] dMemAddr,
	input logic [31:0] dMemDout,
	output logic [31:0] dMemDi,
	input logic rfWe,
	input logic [4:0] rfRa1,
	input logic [4:0] rfRa2,
	input logic [4:0] rfWa1,
	input logic [31:0] rfWd,
	output logic [31:0] rfRd1,
	output logic [31:0] rfRd2
);

	logic [31:0] imem [0:1023]; // Loaded by the testbench
	logic [31:0] dmem [0:4095];
	logic [31:0] rf [0:31];

	initial begin
		for (int i = 0; i < 4096; i++)
			dmem[i] = {i[11:0], 8'h5a, ~i[11:0]};
		for (int i = 0; i < 32; i++)
			rf[i] = '0;
	end

	assign iMemDi = imem[iMemAddr[11:2]];
	assign dMemDi = dMemCsn ? '0 : dmem[dMemAddr]; // Only selected reads return data
	assign rfRd1 = (rfRa1 == 5'd0) ? '0 : rf[rfRa1];
	assign rfRd2 = (rfRa2 == 5'd0) ? '0 : rf[rfRa2];

	always @(posedge CLK) begin
		if (!dMemCsn && !dMemWen) begin
			for (int k = 0; k < 4; k++)
				if (dMemBe[k])
					dmem[dMemAddr][8*k +: 8] <= dMemDout[8*k +: 8];
		end
		if (rfWe)
			rf[rfWa1] <= rfWd;
	end

endmodule

//--- riscvTb.sv
`timescale 1ns/100ps

module riscvTb;
	import riscvIsaPkg::*;

	logic CLK;
	logic RSTn;
	logic iMemCsn;
	logic [31:0] iMemDi;
	logic [11:0] iMemAddr;
	logic dMemCsn;
	logic [31:0] dMemDi;
	logic [31:0] dMemDout;
	logic [11:0] dMemAddr;
	logic dMemWen;
	logic [3:0] dMemBe;
	logic rfWe;
	logic [4:0] rfRa1;
	logic [4:0] rfRa2;
	logic [4:0] rfWa1;
	logic [31:0] rfRd1;
	logic [31:0] rfRd2;
	logic [31:0] rfWd;
	logic halt;
	logic [31:0] numInst;

	int errors = 0;
	int seed = 32'hfebf;
	logic [31:0] prog [$];
	bit executed [$];
	logic [11:0] fetchLog [$];
	logic [15:0] writeLog [$]; // {word address, lanes}
	logic [15:0] expWrites [$];
	logic [31:0] expReg [0:31];
	bit expValid [0:31];
	logic [31:0] shadow [0:2]; // Data words 0x40..0x42

	riscvTop dut0 (.*);
	tbModels models0 (.*);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	always @(negedge CLK) begin
		if (!iMemCsn)
			fetchLog.push_back(iMemAddr);
		if (!dMemWen)
			writeLog.push_back({dMemAddr, dMemBe});
	end

	function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
		return {imm[11:5], rs2, 5'd1, f3, imm[4:0], OP_STORE}; // Base always x1
	endfunction

	function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	function automatic bit branchTaken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
			F3_BEQ:  return a == b;
			F3_BNE:  return a != b;
			F3_BLT:  return $signed(a) < $signed(b);
			F3_BGE:  return $signed(a) >= $signed(b);
			F3_BLTU: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic check32(string name, logic [31:0] exp, logic [31:0] act);
		if (exp !== act) begin
			$display("Mismatch %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic newProgram();
		prog.delete();
		executed.delete();
		expWrites.delete();
		for (int r = 0; r < 32; r++)
			expValid[r] = 0;
		expValid[0] = 1;
		expReg[0] = '0;
	endtask

	task automatic emitOp(logic [31:0] insn, bit ex);
		prog.push_back(insn);
		executed.push_back(ex);
	endtask

	task automatic emit(logic [31:0] insn);
		emitOp(insn, 1);
	endtask

	function automatic logic [31:0] pcNow();
		return 32'(prog.size() * 4);
	endfunction

	task automatic setExp(logic [4:0] rd, logic [31:0] value);
		expReg[rd] = value;
		expValid[rd] = 1;
	endtask

	task automatic emitLi(logic [4:0] rd, logic [31:0] value);
		logic [31:0] hi;
		hi = value + 32'h800; // Compensates the sign of the ADDI part
		emit({hi[31:12], rd, OP_LUI});
		emit(encI(value[11:0], rd, F3_ADD_SUB, rd, OP_IMM));
		setExp(rd, value);
	endtask

	task automatic checkIdle(string when);
		check32({"numInst ", when}, 32'd0, numInst);
		check32({"halt ", when}, 32'd0, 32'(halt));
		check32({"iMemCsn ", when}, 32'd1, 32'(iMemCsn));
		check32({"dMemCsn ", when}, 32'd1, 32'(dMemCsn));
		check32({"rfWe ", when}, 32'd0, 32'(rfWe));
		check32({"dMemWen ", when}, 32'd1, 32'(dMemWen));
	endtask

	// Loads the program while reset is held
	task automatic applyReset();
		@(posedge CLK);
		#1 RSTn = 1'b1;
		for (int i = 0; i < 1024; i++)
			models0.imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
		repeat (3) begin
			@(posedge CLK);
			@(negedge CLK);
			checkIdle("during reset");
		end
		@(posedge CLK);
		#1 RSTn = 1'b0;
		fetchLog.delete();
		writeLog.delete();
		@(negedge CLK);
		checkIdle("after reset");
	endtask

	task automatic runProgram();
		int n;
		int count;
		logic [11:0] expTrace [$];
		applyReset();
		for (n = 0; n < 200 && !halt; n++)
			@(negedge CLK);
		if (!halt) begin
			$display("Timeout waiting for halt after 200 cycles");
			errors++;
		end
		count = 0;
		for (int i = 0; i < prog.size(); i++)
			if (executed[i]) begin
				expTrace.push_back(12'(i * 4));
				count++;
			end
		check32("numInst", 32'(count), numInst);
		if (fetchLog.size() != expTrace.size()) begin
			$display("Fetch sequence has %0d entries but %0d were expected",
				fetchLog.size(), expTrace.size());
			errors++;
		end else begin
			for (int i = 0; i < expTrace.size(); i++)
				check32("iMemAddr", 32'(expTrace[i]), 32'(fetchLog[i]));
		end
	endtask

	task automatic checkRegs();
		for (int r = 0; r < 32; r++)
			if (expValid[r])
				check32($sformatf("x%0d", r), expReg[r], models0.rf[r]);
	endtask

	task automatic emitR(logic [4:0] rd, logic [6:0] f7, logic [2:0] f3, logic [31:0] exp);
		emit(encR(f7, 5'd2, 5'd1, f3, rd));
		setExp(rd, exp);
	endtask

	task automatic emitImm(logic [4:0] rd, logic [2:0] f3, logic [11:0] imm, logic [31:0] exp);
		emit(encI(imm, 5'd1, f3, rd, OP_IMM));
		setExp(rd, exp);
	endtask

	task automatic testAluOps();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [31:0] immS;
		logic [4:0] sh;
		a = $random(seed);
		b = $random(seed);
		r = $random(seed);
		immS = {{20{r[11]}}, r[11:0]};
		sh = r[20:16];
		newProgram();
		emitLi(5'd1, a);
		emitLi(5'd2, b);
		emitR(5'd3, F7_BASE, F3_ADD_SUB, a + b);
		emitR(5'd4, F7_ALT, F3_ADD_SUB, a - b);
		emitR(5'd5, F7_BASE, F3_SLL, a << b[4:0]);
		emitR(5'd6, F7_BASE, F3_SLT, {31'b0, $signed(a) < $signed(b)});
		emitR(5'd7, F7_BASE, F3_SLTU, {31'b0, a < b});
		emitR(5'd8, F7_BASE, F3_XOR, a ^ b);
		emitR(5'd9, F7_BASE, F3_SR, a >> b[4:0]);
		emitR(5'd10, F7_ALT, F3_SR, $signed(a) >>> b[4:0]);
		emitR(5'd11, F7_BASE, F3_OR, a | b);
		emitR(5'd12, F7_BASE, 3'b111, a & b);
		emitImm(5'd13, F3_ADD_SUB, r[11:0], a + immS);
		emitImm(5'd14, F3_SLT, r[11:0], {31'b0, $signed(a) < $signed(immS)});
		emitImm(5'd15, F3_SLTU, r[11:0], {31'b0, a < immS});
		emitImm(5'd16, F3_XOR, r[11:0], a ^ immS);
		emitImm(5'd17, F3_OR, r[11:0], a | immS);
		emitImm(5'd18, 3'b111, r[11:0], a & immS);
		emitImm(5'd19, F3_SLL, {7'b0, sh}, a << sh);
		emitImm(5'd20, F3_SR, {7'b0, sh}, a >> sh);
		emitImm(5'd21, F3_SR, {F7_ALT, sh}, $signed(a) >>> sh);
		emit(encR(F7_BASE, 5'd2, 5'd1, F3_ADD_SUB, 5'd0)); // Write to x0 is dropped
		emit(EBREAK_INSN);
		runProgram();
		checkRegs();
	endtask

	task automatic emitStore(logic [2:0] f3, logic [4:0] rs2, logic [11:0] off);
		logic [3:0] be;
		logic [31:0] data;
		int w;
		data = expReg[rs2];
		w = int'(off >> 2);
		case (f3)
			F3_SB:   be = 4'b0001 << off[1:0];
			F3_SH:   be = off[1] ? 4'b1100 : 4'b0011;
			default: be = 4'b1111;
		endcase
		for (int k = 0; k < 4; k++)
			if (be[k])
				shadow[w][8*k +: 8] = (f3 == F3_SB) ? data[7:0] :
					(f3 == F3_SH) ? data[8*(k%2) +: 8] : data[8*k +: 8];
		emit(encS(off, rs2, f3));
		expWrites.push_back({12'h040 + 12'(w), be});
	endtask

	task automatic emitLoad(logic [4:0] rd, logic [2:0] f3, logic [11:0] off);
		logic [31:0] s;
		s = shadow[off >> 2] >> (8 * off[1:0]);
		case (f3)
			F3_LB:   setExp(rd, {{24{s[7]}}, s[7:0]});
			F3_LBU:  setExp(rd, {24'b0, s[7:0]});
			F3_LH:   setExp(rd, {{16{s[15]}}, s[15:0]});
			F3_LHU:  setExp(rd, {16'b0, s[15:0]});
			default: setExp(rd, s);
		endcase
		emit(encI(off, 5'd1, f3, rd, OP_LOAD));
	endtask

	task automatic testLoadStore();
		logic [31:0] va;
		logic [31:0] vb;
		va = $random(seed);
		vb = $random(seed);
		newProgram();
		for (int k = 0; k < 3; k++)
			shadow[k] = models0.dmem[12'h040 + k];
		emitLi(5'd1, 32'h100);
		emitLi(5'd2, va | 32'h0000_8080);
		emitLi(5'd3, vb | 32'h8080_8080); // Sign bits set for the extension checks
		emitStore(F3_SW, 5'd2, 12'd0);
		emitStore(F3_SB, 5'd2, 12'd4);
		emitStore(F3_SB, 5'd3, 12'd5);
		emitStore(F3_SB, 5'd2, 12'd6);
		emitStore(F3_SB, 5'd3, 12'd7);
		emitStore(F3_SH, 5'd3, 12'd8);
		emitStore(F3_SH, 5'd2, 12'd10);
		emitLoad(5'd10, F3_LW, 12'd0);
		emitLoad(5'd11, F3_LW, 12'd4);
		emitLoad(5'd12, F3_LB, 12'd5);
		emitLoad(5'd13, F3_LBU, 12'd5);
		emitLoad(5'd14, F3_LB, 12'd6);
		emitLoad(5'd15, F3_LBU, 12'd4);
		emitLoad(5'd16, F3_LH, 12'd8);
		emitLoad(5'd17, F3_LHU, 12'd10);
		emitLoad(5'd18, F3_LH, 12'd10);
		emitLoad(5'd19, F3_LHU, 12'd8);
		emitLoad(5'd20, F3_LB, 12'd7);
		emit(EBREAK_INSN);
		runProgram();
		checkRegs();
		if (writeLog.size() != expWrites.size()) begin
			$display("Saw %0d data writes but %0d were expected", writeLog.size(),
				expWrites.size());
			errors++;
		end else begin
			for (int i = 0; i < expWrites.size(); i++) begin
				check32("dMemAddr", 32'(expWrites[i][15:4]), 32'(writeLog[i][15:4]));
				check32("dMemBe", 32'(expWrites[i][3:0]), 32'(writeLog[i][3:0]));
			end
		end
		for (int k = 0; k < 3; k++)
			check32($sformatf("dmem[%0h]", 12'h040 + k), shadow[k], models0.dmem[12'h040 + k]);
	endtask

	// Taken skips the marker ADDI
	task automatic emitBranch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2);
		bit t;
		t = branchTaken(f3, expReg[rs1], expReg[rs2]);
		emit(encB(13'd8, rs2, rs1, f3));
		emitOp(encI(12'd1, 5'd10, F3_ADD_SUB, 5'd10, OP_IMM), !t);
		if (!t)
			expReg[10] = expReg[10] + 32'd1;
	endtask

	task automatic testBranches();
		logic [31:0] p;
		newProgram();
		emitLi(5'd1, 32'd5);
		emitLi(5'd2, 32'hFFFF_FFFD);
		emitLi(5'd10, 32'd0);
		emitBranch(F3_BEQ, 5'd1, 5'd1);
		emitBranch(F3_BEQ, 5'd1, 5'd2);
		emitBranch(F3_BNE, 5'd1, 5'd2);
		emitBranch(F3_BNE, 5'd1, 5'd1);
		emitBranch(F3_BLT, 5'd2, 5'd1);
		emitBranch(F3_BLT, 5'd1, 5'd2);
		emitBranch(F3_BGE, 5'd1, 5'd2);
		emitBranch(F3_BGE, 5'd2, 5'd1);
		emitBranch(F3_BLTU, 5'd1, 5'd2);
		emitBranch(F3_BLTU, 5'd2, 5'd1);
		emitBranch(F3_BGEU, 5'd2, 5'd1);
		emitBranch(F3_BGEU, 5'd1, 5'd2);
		p = pcNow();
		emit(encJ(21'd8, 5'd5));
		setExp(5'd5, p + 32'd4);
		emitOp(encI(12'd1, 5'd10, F3_ADD_SUB, 5'd10, OP_IMM), 0);
		p = pcNow();
		emit(encI(12'(p + 32'd13), 5'd0, F3_ADD_SUB, 5'd6, OP_IMM)); // Odd target
		setExp(5'd6, p + 32'd13);
		emit(encI(12'd0, 5'd6, 3'b000, 5'd7, OP_JALR));
		setExp(5'd7, p + 32'd8);
		emitOp(encI(12'd1, 5'd10, F3_ADD_SUB, 5'd10, OP_IMM), 0);
		emit(EBREAK_INSN);
		runProgram();
		checkRegs();
	endtask

	task automatic testUpper();
		logic [31:0] r;
		newProgram();
		r = $random(seed);
		emit({r[31:12], 5'd1, OP_LUI});
		setExp(5'd1, {r[31:12], 12'b0});
		r = $random(seed);
		emit({r[31:12], 5'd2, OP_AUIPC});
		setExp(5'd2, {r[31:12], 12'b0} + 32'd4);
		r = $random(seed);
		emit({r[31:12], 5'd3, OP_AUIPC});
		setExp(5'd3, {r[31:12], 12'b0} + 32'd8);
		emit(EBREAK_INSN);
		runProgram();
		checkRegs();
	endtask

	// Runs on the halted state of the previous program
	task automatic testHalt();
		logic [31:0] count;
		logic [31:0] stopPc;
		count = 0;
		for (int i = 0; i < executed.size(); i++)
			if (executed[i])
				count++;
		stopPc = pcNow() - 32'd4;
		repeat (10) begin
			@(negedge CLK);
			check32("halt", 32'd1, 32'(halt));
			check32("iMemCsn", 32'd1, 32'(iMemCsn));
			check32("iMemAddr", stopPc, 32'(iMemAddr));
			check32("numInst", count, numInst);
			check32("rfWe", 32'd0, 32'(rfWe));
			check32("dMemWen", 32'd1, 32'(dMemWen));
		end
	endtask

	task automatic testMidReset();
		int n;
		newProgram();
		emit(encI(12'd1, 5'd1, F3_ADD_SUB, 5'd1, OP_IMM));
		emit(encI(12'd1, 5'd1, F3_ADD_SUB, 5'd1, OP_IMM));
		emit(encJ(21'h1F_FFFC, 5'd0)); // Loops back to address 4, never to 0
		applyReset();
		repeat (20) @(negedge CLK);
		check32("halt", 32'd0, 32'(halt));
		applyReset();
		for (n = 0; n < 10 && fetchLog.size() == 0; n++)
			@(negedge CLK);
		if (fetchLog.size() == 0) begin
			$display("Timeout waiting for the first fetch after reset");
			errors++;
		end else begin
			check32("iMemAddr", 32'd0, 32'(fetchLog[0]));
		end
	endtask

	initial begin
		RSTn = 1'b1;
		testAluOps();
		testLoadStore();
		testBranches();
		testUpper();
		testHalt();
		testMidReset();
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- src.f
riscvIsaPkg.sv
riscvCorePkg.sv
pcUnit.sv
controlDecoder.sv
immGen.sv
alu.sv
memAccess.sv
riscvTop.sv
tbModels.sv
riscvTb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module riscvTb -f src.f -o simv
if [ $? -ne 0 ]; then
	echo "Compilation failed"
	exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
